//--- build.f
src/gw_tag_pkg.sv
src/gw_trace_pkg.sv
src/gw_trace_ram.sv
src/gw_tag_trace_replay.sv
src/gw_tag_master.sv
src/gw_tag_client.sv
src/gw_gateway_top.sv
test/tb_gateway.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_gateway \
  -f build.f \
  -o Vtb_gateway

out=$(./obj_dir/Vtb_gateway)
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi

//--- src/gw_gateway_top.sv
`timescale 1ns/10ps

module gw_gateway_top #(
  parameter int TRACE_ADDR_W = 6,
  parameter int NUM_CLIENTS  = 3
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    trace_we_i,
  input  logic [TRACE_ADDR_W-1:0] trace_addr_i,
  input  gw_trace_pkg::trace_entry_t trace_data_i,
  input  logic                    run_i,
  output logic                    pin_tag_data_o,
  output logic                    pin_tag_en_o,
  output logic                    done_o,
  output gw_tag_pkg::client_cfg_t cfg_o [NUM_CLIENTS]
);

  import gw_tag_pkg::*;
  import gw_trace_pkg::*;

  logic [TRACE_ADDR_W-1:0] rom_addr;
  trace_entry_t            rom_data;
  logic                    tag_data;
  logic [NUM_MASTERS-1:0]  tag_en;
  tag_line_t               lines [NUM_CLIENTS];

  //////////////////////////////////////////////////////////////////////
  // Trace script and replay
  //////////////////////////////////////////////////////////////////////

  gw_trace_ram #(.TRACE_ADDR_W(TRACE_ADDR_W)) u_trace_ram (
    .clk_i   (clk_i),
    .we_i    (trace_we_i),
    .waddr_i (trace_addr_i),
    .wdata_i (trace_data_i),
    .raddr_i (rom_addr),
    .rdata_o (rom_data)
  );

  gw_tag_trace_replay #(.TRACE_ADDR_W(TRACE_ADDR_W)) u_replay (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .run_i      (run_i),
    .rom_data_i (rom_data),
    .rom_addr_o (rom_addr),
    .tag_data_o (tag_data),
    .tag_en_o   (tag_en),
    .done_o     (done_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Local tag master and its clients
  //////////////////////////////////////////////////////////////////////

  gw_tag_master #(.NUM_CLIENTS(NUM_CLIENTS)) u_master (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (tag_data),
    .en_i    (tag_en[0]),
    .lines_o (lines)
  );

  for (genvar k = 0; k < NUM_CLIENTS; k++)
  begin : g_client
    gw_tag_client u_client (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .line_i  (lines[k]),
      .cfg_o   (cfg_o[k])
    );
  end

  // Master 1 goes off chip
  assign pin_tag_data_o = tag_data;
  assign pin_tag_en_o   = tag_en[1];

endmodule

//--- src/gw_tag_client.sv
`timescale 1ns/10ps

module gw_tag_client (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  gw_tag_pkg::tag_line_t   line_i,
  output gw_tag_pkg::client_cfg_t cfg_o
);

  import gw_tag_pkg::*;

  logic [PAYLOAD_W-1:0] shadow_q, shadow_d;
  client_cfg_t          cfg_q;

  // Last payload bit and commit can arrive together
  always_comb
  begin
    if (line_i.start)
    begin
      shadow_d = '0;
    end
    else if (line_i.shift)
    begin
      shadow_d = {shadow_q[PAYLOAD_W-2:0], line_i.data};
    end
    else
    begin
      shadow_d = shadow_q;
    end
  end

  always_ff @(posedge clk_i)
  begin
    shadow_q <= shadow_d;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cfg_q <= '0;
    end
    else
    begin
      cfg_q.v <= line_i.commit;
      if (line_i.commit)
      begin
        cfg_q.value <= shadow_d;
      end
    end
  end

  assign cfg_o = cfg_q;

endmodule

//--- src/gw_tag_master.sv
`timescale 1ns/10ps

module gw_tag_master #(
  parameter int NUM_CLIENTS = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  data_i,
  input  logic                  en_i,
  output gw_tag_pkg::tag_line_t lines_o [NUM_CLIENTS]
);

  import gw_tag_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ID,
    ST_LEN,
    ST_PAYLOAD
  } state_e;

  state_e                 state_q, state_d;
  logic [LEN_W-1:0]       cnt_q, cnt_d;
  logic [CLIENT_ID_W-1:0] id_q, id_d;
  logic [LEN_W-1:0]       len_q, len_d;
  logic [LEN_W-1:0]       len_full;
  // Zero length packets commit one cycle after start
  logic                   pend_q, pend_d;
  logic [CLIENT_ID_W-1:0] pend_id_q, pend_id_d;
  tag_line_t              ev;
  tag_line_t              lines_q [NUM_CLIENTS];
  tag_line_t              lines_d [NUM_CLIENTS];

  assign len_full = {len_q[LEN_W-2:0], data_i};

  always_comb
  begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    id_d      = id_q;
    len_d     = len_q;
    pend_d    = 1'b0;
    pend_id_d = pend_id_q;
    ev        = '0;
    case (state_q)
      ST_IDLE:
      begin
        if (en_i && data_i)
        begin
          state_d = ST_ID;
          cnt_d   = LEN_W'(CLIENT_ID_W - 1);
        end
      end
      ST_ID:
      begin
        id_d = {id_q[CLIENT_ID_W-2:0], data_i};
        if (cnt_q == '0)
        begin
          state_d = ST_LEN;
          cnt_d   = LEN_W'(LEN_W - 1);
        end
        else
        begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      ST_LEN:
      begin
        len_d = len_full;
        if (cnt_q == '0)
        begin
          ev.start = 1'b1;
          if (len_full == '0)
          begin
            pend_d    = 1'b1;
            pend_id_d = id_q;
            state_d   = ST_IDLE;
          end
          else
          begin
            cnt_d   = len_full - 1'b1;
            state_d = ST_PAYLOAD;
          end
        end
        else
        begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      default:
      begin
        ev.shift = 1'b1;
        ev.data  = data_i;
        if (cnt_q == '0)
        begin
          ev.commit = 1'b1;
          state_d   = ST_IDLE;
        end
        else
        begin
          cnt_d = cnt_q - 1'b1;
        end
      end
    endcase

    // Enable dropped mid packet, abandon it
    if (!en_i && state_q != ST_IDLE)
    begin
      state_d = ST_IDLE;
      pend_d  = 1'b0;
      ev      = '0;
    end

    // Out of range ids match no line
    for (int k = 0; k < NUM_CLIENTS; k++)
    begin
      lines_d[k] = (id_q == CLIENT_ID_W'(k)) ? ev : '0;
      if (pend_q && pend_id_q == CLIENT_ID_W'(k))
      begin
        lines_d[k].commit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      pend_q  <= 1'b0;
      for (int k = 0; k < NUM_CLIENTS; k++)
      begin
        lines_q[k] <= '0;
      end
    end
    else
    begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      pend_q  <= pend_d;
      lines_q <= lines_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    id_q      <= id_d;
    len_q     <= len_d;
    pend_id_q <= pend_id_d;
  end

  assign lines_o = lines_q;

endmodule

//--- src/gw_tag_pkg.sv
package gw_tag_pkg;

  //////////////////////////////////////////////////////////////////////
  // Packet field widths
  //////////////////////////////////////////////////////////////////////

  // Client id field, MSB first
  localparam int CLIENT_ID_W = 2;

  // Length field, number of payload bits that follow
  localparam int LEN_W = 4;

  // Widest payload, also the client register width
  localparam int PAYLOAD_W = 12;

  // Start bit plus id plus length
  localparam int PKT_HDR_W = 1 + CLIENT_ID_W + LEN_W;

  //////////////////////////////////////////////////////////////////////
  // Master to client
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic start;
    logic shift;
    logic data;
    logic commit;
  } tag_line_t;

  // Committed register of one client, v pulses on update
  typedef struct packed {
    logic                 v;
    logic [PAYLOAD_W-1:0] value;
  } client_cfg_t;

endpackage

//--- src/gw_tag_trace_replay.sv
`timescale 1ns/10ps

module gw_tag_trace_replay #(
  parameter int TRACE_ADDR_W = 6
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 run_i,
  input  gw_trace_pkg::trace_entry_t           rom_data_i,
  output logic [TRACE_ADDR_W-1:0]              rom_addr_o,
  output logic                                 tag_data_o,
  output logic [gw_trace_pkg::NUM_MASTERS-1:0] tag_en_o,
  output logic                                 done_o
);

  import gw_tag_pkg::*;
  import gw_trace_pkg::*;

  // Bits left after the start bit
  localparam int SHIFT_W = PKT_HDR_W + PAYLOAD_W - 1;
  localparam int CNT_W   = $clog2(PKT_HDR_W + PAYLOAD_W);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_SEND,
    ST_WAIT,
    ST_DONE
  } state_e;

  state_e                  state_q;
  logic [TRACE_ADDR_W-1:0] addr_q;
  logic [SHIFT_W-1:0]      shift_q;
  logic [CNT_W-1:0]        bit_cnt_q;
  logic [WAIT_W-1:0]       wait_cnt_q;
  logic                    tag_data_q;
  logic [NUM_MASTERS-1:0]  tag_en_q;
  logic                    done_q;

  send_body_t              snd;
  wait_body_t              dly;
  logic [LEN_W-1:0]        len_eff;
  logic [PAYLOAD_W-1:0]    pay_aligned;
  logic [NUM_MASTERS-1:0]  en_sel;

  //////////////////////////////////////////////////////////////////////
  // Entry decode
  //////////////////////////////////////////////////////////////////////

  assign snd = rom_data_i.body.send;
  assign dly = rom_data_i.body.delay;

  // Length never exceeds the client register
  assign len_eff = (snd.len > LEN_W'(PAYLOAD_W)) ? LEN_W'(PAYLOAD_W) : snd.len;

  // Low L payload bits moved to the top, sent MSB first
  assign pay_aligned = snd.payload << (LEN_W'(PAYLOAD_W) - len_eff);

  assign en_sel = NUM_MASTERS'(1) << snd.master;

  //////////////////////////////////////////////////////////////////////
  // Replay FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= ST_IDLE;
      addr_q     <= '0;
      bit_cnt_q  <= '0;
      wait_cnt_q <= '0;
      tag_data_q <= 1'b0;
      tag_en_q   <= '0;
      done_q     <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (run_i)
          begin
            state_q <= ST_FETCH;
          end
        end
        // Address is out, data lands next cycle
        ST_FETCH:
        begin
          state_q <= ST_DECODE;
        end
        ST_DECODE:
        begin
          case (rom_data_i.op)
            OP_SEND:
            begin
              tag_data_q <= 1'b1;
              tag_en_q   <= en_sel;
              bit_cnt_q  <= CNT_W'(PKT_HDR_W - 1) + CNT_W'(len_eff);
              addr_q     <= addr_q + 1'b1;
              state_q    <= ST_SEND;
            end
            OP_WAIT:
            begin
              addr_q <= addr_q + 1'b1;
              if (dly.cycles == '0)
              begin
                state_q <= ST_FETCH;
              end
              else
              begin
                wait_cnt_q <= dly.cycles - 1'b1;
                state_q    <= ST_WAIT;
              end
            end
            OP_NOP:
            begin
              addr_q  <= addr_q + 1'b1;
              state_q <= ST_FETCH;
            end
            default:
            begin
              done_q  <= 1'b1;
              state_q <= ST_DONE;
            end
          endcase
        end
        ST_SEND:
        begin
          if (bit_cnt_q == '0)
          begin
            tag_data_q <= 1'b0;
            tag_en_q   <= '0;
            state_q    <= ST_FETCH;
          end
          else
          begin
            tag_data_q <= shift_q[SHIFT_W-1];
            bit_cnt_q  <= bit_cnt_q - 1'b1;
          end
        end
        ST_WAIT:
        begin
          if (wait_cnt_q == '0)
          begin
            state_q <= ST_FETCH;
          end
          else
          begin
            wait_cnt_q <= wait_cnt_q - 1'b1;
          end
        end
        default:
        begin
          state_q <= ST_DONE;
        end
      endcase
    end
  end

  // Packet body after the start bit
  always_ff @(posedge clk_i)
  begin
    if (state_q == ST_DECODE)
    begin
      shift_q <= {snd.client_id, len_eff, pay_aligned};
    end
    else if (state_q == ST_SEND)
    begin
      shift_q <= shift_q << 1;
    end
  end

  assign rom_addr_o = addr_q;
  assign tag_data_o = tag_data_q;
  assign tag_en_o   = tag_en_q;
  assign done_o     = done_q;

endmodule

//--- src/gw_trace_pkg.sv
package gw_trace_pkg;

  // Master 0 is the local tag master, master 1 drives the pins
  localparam int NUM_MASTERS = 2;
  localparam int MASTER_W    = $clog2(NUM_MASTERS);

  localparam int WAIT_W = 16;

  //////////////////////////////////////////////////////////////////////
  // Trace entry format
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_SEND = 2'd0,
    OP_WAIT = 2'd1,
    OP_DONE = 2'd2,
    OP_NOP  = 2'd3
  } trace_op_e;

  typedef struct packed {
    logic [MASTER_W-1:0]                master;
    logic [gw_tag_pkg::CLIENT_ID_W-1:0] client_id;
    logic [gw_tag_pkg::LEN_W-1:0]       len;
    logic [gw_tag_pkg::PAYLOAD_W-1:0]   payload;
  } send_body_t;

  // Pad keeps both bodies the same width
  typedef struct packed {
    logic [2:0]        pad;
    logic [WAIT_W-1:0] cycles;
  } wait_body_t;

  // Same 19 bits, meaning chosen by op
  typedef union packed {
    send_body_t send;
    wait_body_t delay;
  } trace_body_u;

  typedef struct packed {
    trace_op_e   op;
    trace_body_u body;
  } trace_entry_t;

endpackage

//--- src/gw_trace_ram.sv
`timescale 1ns/10ps

module gw_trace_ram #(
  parameter int TRACE_ADDR_W = 6
) (
  input  logic                        clk_i,
  input  logic                        we_i,
  input  logic [TRACE_ADDR_W-1:0]     waddr_i,
  input  gw_trace_pkg::trace_entry_t  wdata_i,
  input  logic [TRACE_ADDR_W-1:0]     raddr_i,
  output gw_trace_pkg::trace_entry_t  rdata_o
);

  import gw_trace_pkg::*;

  localparam int DEPTH = 2 ** TRACE_ADDR_W;

  trace_entry_t mem_q [DEPTH];
  trace_entry_t rdata_q;

  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk_i)
  begin
    rdata_q <= mem_q[raddr_i];
  end

  assign rdata_o = rdata_q;

endmodule

//--- test/tb_gateway.sv
`timescale 1ns/10ps

module tb_gateway;

  import gw_tag_pkg::*;
  import gw_trace_pkg::*;

  localparam int TRACE_ADDR_W    = 6;
  localparam int NUM_CLIENTS     = 3;
  localparam int NUM_RANDOM      = 48;
  localparam int NUM_ENTRIES     = NUM_RANDOM + 1;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 40 + 200;
  localparam logic [31:0] SEED   = 32'd62;

  // Expected local client updates in trace order
  typedef struct packed {
    logic [CLIENT_ID_W-1:0] id;
    logic [PAYLOAD_W-1:0]   value;
  } cfg_exp_t;

  // Expected pin packet
  typedef struct packed {
    logic [CLIENT_ID_W-1:0] id;
    logic [LEN_W-1:0]       len;
    logic [PAYLOAD_W-1:0]   bits;
  } pin_pkt_t;

  logic                    clk;
  logic                    rst_n;
  logic                    trace_we;
  logic [TRACE_ADDR_W-1:0] trace_addr;
  trace_entry_t            trace_data;
  logic                    run;
  logic                    pin_data;
  logic                    pin_en;
  logic                    done;
  client_cfg_t             cfg [NUM_CLIENTS];

  trace_entry_t            trace_mem [NUM_ENTRIES];
  cfg_exp_t                exp_cfg_q[$];
  pin_pkt_t                exp_pin_q[$];
  int                      min_cycles;

  int                      n_checks;
  int                      n_errors;
  int                      cyc;
  int                      run_cyc;
  int                      done_cyc;
  logic                    run_seen;
  logic                    done_seen;
  logic [31:0]             pin_acc;
  int                      pin_cnt;

  gw_gateway_top #(
    .TRACE_ADDR_W (TRACE_ADDR_W),
    .NUM_CLIENTS  (NUM_CLIENTS)
  ) i_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .trace_we_i     (trace_we),
    .trace_addr_i   (trace_addr),
    .trace_data_i   (trace_data),
    .run_i          (run),
    .pin_tag_data_o (pin_data),
    .pin_tag_en_o   (pin_en),
    .done_o         (done),
    .cfg_o          (cfg)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Random script and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic build_trace();
    logic [31:0]  rng;
    trace_entry_t e;
    cfg_exp_t     ce;
    pin_pkt_t     pp;
    int           pick;
    int           mask;
    rng        = SEED;
    min_cycles = 0;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      e    = '0;
      rng  = xorshift32(rng);
      pick = int'(rng % 32'd100);
      rng  = xorshift32(rng);
      if (pick < 60)
      begin
        e.op                  = OP_SEND;
        e.body.send.master    = rng[0];
        e.body.send.client_id = rng[9:8];
        e.body.send.len       = LEN_W'((rng >> 16) % 32'd13);
        rng                   = xorshift32(rng);
        e.body.send.payload   = rng[PAYLOAD_W-1:0];
        mask                  = (1 << e.body.send.len) - 1;
        min_cycles            = min_cycles + PKT_HDR_W + int'(e.body.send.len);
        if (e.body.send.master == 1'b1)
        begin
          pp.id   = e.body.send.client_id;
          pp.len  = e.body.send.len;
          pp.bits = e.body.send.payload & PAYLOAD_W'(mask);
          exp_pin_q.push_back(pp);
        end
        else if (e.body.send.client_id < NUM_CLIENTS)
        begin
          ce.id    = e.body.send.client_id;
          ce.value = e.body.send.payload & PAYLOAD_W'(mask);
          exp_cfg_q.push_back(ce);
        end
      end
      else if (pick < 85)
      begin
        e.op                = OP_WAIT;
        e.body.delay.cycles = WAIT_W'(rng % 32'd21);
        min_cycles          = min_cycles + int'(e.body.delay.cycles);
      end
      else
      begin
        e.op = OP_NOP;
      end
      trace_mem[i] = e;
    end
    e                       = '0;
    e.op                    = OP_DONE;
    trace_mem[NUM_RANDOM]   = e;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output checks sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic check_idle_outputs();
    for (int k = 0; k < NUM_CLIENTS; k++)
    begin
      n_checks++;
      if (cfg[k].v || cfg[k].value != '0)
      begin
        n_errors++;
        $display("FAIL @%0t: client %0d not idle before run, v %b value %h",
                 $time, k, cfg[k].v, cfg[k].value);
      end
    end
    n_checks++;
    if (pin_en || done)
    begin
      n_errors++;
      $display("FAIL @%0t: pin enable %b or done %b high before run", $time, pin_en, done);
    end
  endtask

  task automatic check_cfg_pulses();
    cfg_exp_t exp;
    for (int k = 0; k < NUM_CLIENTS; k++)
    begin
      if (cfg[k].v)
      begin
        n_checks++;
        if (done_seen)
        begin
          n_errors++;
          $display("Client %0d pulsed after done rose, at %0t", k, $time);
        end
        else if (exp_cfg_q.size() == 0)
        begin
          n_errors++;
          $display("Client %0d pulsed with no update expected, at %0t", k, $time);
        end
        else
        begin
          exp = exp_cfg_q.pop_front();
          if (exp.id != CLIENT_ID_W'(k) || exp.value != cfg[k].value)
          begin
            n_errors++;
            $display("FAIL @%0t: client %0d value %h, expected client %0d value %h",
                     $time, k, cfg[k].value, exp.id, exp.value);
          end
        end
      end
    end
  endtask

  task automatic check_pin_burst();
    pin_pkt_t               exp;
    logic                   start;
    logic [CLIENT_ID_W-1:0] id;
    logic [LEN_W-1:0]       len;
    logic [PAYLOAD_W-1:0]   bits;
    int                     pay_n;
    n_checks++;
    if (pin_cnt < PKT_HDR_W || pin_cnt > PKT_HDR_W + PAYLOAD_W)
    begin
      n_errors++;
      $display("Pin burst of %0d bits cannot be a packet, at %0t", pin_cnt, $time);
    end
    else if (exp_pin_q.size() == 0)
    begin
      n_errors++;
      $display("Pin burst seen with no pin packet expected, at %0t", $time);
    end
    else
    begin
      pay_n = pin_cnt - PKT_HDR_W;
      start = pin_acc[pin_cnt-1];
      id    = CLIENT_ID_W'(pin_acc >> (pay_n + LEN_W));
      len   = LEN_W'(pin_acc >> pay_n);
      bits  = PAYLOAD_W'(pin_acc & ((32'd1 << pay_n) - 32'd1));
      exp   = exp_pin_q.pop_front();
      if (!start || id != exp.id || len != exp.len || pay_n != int'(exp.len)
          || bits != exp.bits)
      begin
        n_errors++;
        $display("FAIL @%0t: pin id %0d len %0d bits %h (%0d), expected id %0d len %0d bits %h",
                 $time, id, len, bits, pay_n, exp.id, exp.len, exp.bits);
      end
    end
  endtask

  task automatic collect_pin_bit();
    if (pin_en)
    begin
      if (pin_cnt == 0 && done_seen)
      begin
        n_errors++;
        $display("Pin activity after done rose, at %0t", $time);
      end
      pin_acc = {pin_acc[30:0], pin_data};
      pin_cnt++;
    end
    else if (pin_cnt != 0)
    begin
      check_pin_burst();
      pin_cnt = 0;
      pin_acc = '0;
    end
  endtask

  task automatic track_done();
    if (done_seen && !done)
    begin
      n_errors++;
      $display("FAIL @%0t: done_o fell after rising", $time);
    end
    if (done && !done_seen)
    begin
      done_seen = 1'b1;
      done_cyc  = cyc;
      n_checks++;
      if (!run_seen || done_cyc - run_cyc < min_cycles)
      begin
        n_errors++;
        $display("FAIL @%0t: done after %0d cycles, at least %0d expected",
                 $time, done_cyc - run_cyc, min_cycles);
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      cyc++;
      if (!run)
      begin
        check_idle_outputs();
      end
      else if (!run_seen)
      begin
        run_seen = 1'b1;
        run_cyc  = cyc;
      end
      check_cfg_pulses();
      collect_pin_bit();
      track_done();
    end
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, done_o never rose", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n      = 1'b0;
    trace_we   = 1'b0;
    trace_addr = '0;
    trace_data = '0;
    run        = 1'b0;
    n_checks   = 0;
    n_errors   = 0;
    cyc        = 0;
    run_cyc    = 0;
    done_cyc   = 0;
    run_seen   = 1'b0;
    done_seen  = 1'b0;
    pin_acc    = '0;
    pin_cnt    = 0;
    build_trace();
    $display("Script of %0d entries, %0d local updates and %0d pin packets expected",
             NUM_ENTRIES, exp_cfg_q.size(), exp_pin_q.size());

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Load the script through the write port
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      @(posedge clk);
      trace_we   <= 1'b1;
      trace_addr <= TRACE_ADDR_W'(i);
      trace_data <= trace_mem[i];
    end
    @(posedge clk);
    trace_we <= 1'b0;
    repeat (3) @(posedge clk);
    run <= 1'b1;

    while (!done_seen)
    begin
      @(posedge clk);
    end
    // Quiet tail to catch late activity
    repeat (30) @(posedge clk);

    n_checks++;
    if (exp_cfg_q.size() != 0)
    begin
      n_errors++;
      $display("%0d expected client updates never arrived", exp_cfg_q.size());
    end
    n_checks++;
    if (exp_pin_q.size() != 0)
    begin
      n_errors++;
      $display("%0d expected pin packets never arrived", exp_pin_q.size());
    end

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
